// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_jtag_dbg
FILELIST = files.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "simulation exited with an error" >> $(LOG)
	cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dbg_defs.svh ====
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// Debug register map geometry
`define DBG_ADDR_W 4
`define DBG_DATA_W 16

// Instruction register length
`define JTAG_IR_W 4

// Identification code, bit 0 must be one
`define DBG_IDCODE 32'h1A5C_D0E1

// PRBS total-bit counter, read back as two halves
`define PRBS_TOT_W 32

`endif

// ==== dbg_pkg.sv ====
`default_nettype none

`include "dbg_defs.svh"

package dbg_pkg;

	// Debug register bank map
	typedef enum logic [`DBG_ADDR_W-1:0] {
		CTRL    = `DBG_ADDR_W'(0),
		PAD     = `DBG_ADDR_W'(1),
		CMD     = `DBG_ADDR_W'(2),
		ERR_CNT = `DBG_ADDR_W'(3),
		TOT_LO  = `DBG_ADDR_W'(4),
		TOT_HI  = `DBG_ADDR_W'(5),
		STATUS  = `DBG_ADDR_W'(6)
	} dbg_addr_t;

	// PRBS polynomial select, all two-tap
	// PRBS7  x^7  + x^6  + 1
	// PRBS9  x^9  + x^5  + 1
	// PRBS15 x^15 + x^14 + 1
	// PRBS23 x^23 + x^18 + 1
	typedef enum logic [1:0] {
		PRBS7  = 2'd0,
		PRBS9  = 2'd1,
		PRBS15 = 2'd2,
		PRBS23 = 2'd3
	} prbs_poly_t;

endpackage

`default_nettype wire

// ==== dbg_reg_bank.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defs.svh"

module dbg_reg_bank (
	input wire logic clk,
	input wire logic rst_i,

	input wire logic psel_i,
	input wire logic penable_i,
	input wire logic pwrite_i,
	input wire dbg_pkg::dbg_addr_t paddr_i,
	input wire logic [`DBG_DATA_W-1:0] pwdata_i,
	output logic [`DBG_DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,

	output logic [3:0] ibuf_disable_o,
	output logic chk_en_o,
	output logic gen_en_o,
	output dbg_pkg::prbs_poly_t poly_o,
	output logic invert_o,
	output logic clr_cnt_o,
	output logic inj_err_o,
	output logic reseed_o,

	input wire logic [`DBG_DATA_W-1:0] err_cnt_i,
	input wire logic [`PRBS_TOT_W-1:0] tot_cnt_i,
	input wire logic locked_i
);
	logic access;
	logic mapped;
	logic read_only;
	logic acc_err;
	logic wr_en;

	logic chk_en_q;
	logic gen_en_q;
	dbg_pkg::prbs_poly_t poly_q;
	logic invert_q;
	logic [3:0] pad_q;
	logic clr_q;
	logic inj_q;
	logic reseed_q;

	assign access = psel_i & penable_i;

	always_comb begin
		mapped    = 1'b1;
		read_only = 1'b0;
		case (paddr_i)
			dbg_pkg::CTRL, dbg_pkg::PAD, dbg_pkg::CMD: ;
			dbg_pkg::ERR_CNT, dbg_pkg::TOT_LO, dbg_pkg::TOT_HI, dbg_pkg::STATUS: begin
				read_only = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	assign acc_err   = ~mapped | (pwrite_i & read_only);
	assign wr_en     = access & pwrite_i & ~acc_err;
	assign pready_o  = access;
	assign pslverr_o = access & acc_err;

	// Unused bits read as zero
	always_comb begin
		prdata_o = '0;
		case (paddr_i)
			dbg_pkg::CTRL: begin
				prdata_o[0]   = chk_en_q;
				prdata_o[1]   = gen_en_q;
				prdata_o[3:2] = poly_q;
				prdata_o[4]   = invert_q;
			end
			dbg_pkg::PAD:     prdata_o[3:0] = pad_q;
			dbg_pkg::ERR_CNT: prdata_o = err_cnt_i;
			dbg_pkg::TOT_LO:  prdata_o = tot_cnt_i[`DBG_DATA_W-1:0];
			dbg_pkg::TOT_HI:  prdata_o = tot_cnt_i[`PRBS_TOT_W-1:`DBG_DATA_W];
			dbg_pkg::STATUS: begin
				prdata_o[0] = locked_i;
				prdata_o[1] = &err_cnt_i;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			chk_en_q <= 1'b0;
			gen_en_q <= 1'b0;
			poly_q   <= dbg_pkg::PRBS7;
			invert_q <= 1'b0;
			pad_q    <= '0;
		end else if (wr_en) begin
			if (paddr_i == dbg_pkg::CTRL) begin
				chk_en_q <= pwdata_i[0];
				gen_en_q <= pwdata_i[1];
				poly_q   <= dbg_pkg::prbs_poly_t'(pwdata_i[3:2]);
				invert_q <= pwdata_i[4];
			end
			if (paddr_i == dbg_pkg::PAD) begin
				pad_q <= pwdata_i[3:0];
			end
		end
	end

	// CMD bits give single-cycle strobes
	always_ff @(posedge clk) begin
		if (rst_i) begin
			clr_q    <= 1'b0;
			inj_q    <= 1'b0;
			reseed_q <= 1'b0;
		end else begin
			clr_q    <= wr_en & (paddr_i == dbg_pkg::CMD) & pwdata_i[0];
			inj_q    <= wr_en & (paddr_i == dbg_pkg::CMD) & pwdata_i[1];
			reseed_q <= wr_en & (paddr_i == dbg_pkg::CMD) & pwdata_i[2];
		end
	end

	assign ibuf_disable_o = pad_q;
	assign chk_en_o       = chk_en_q;
	assign gen_en_o       = gen_en_q;
	assign poly_o         = poly_q;
	assign invert_o       = invert_q;
	assign clr_cnt_o      = clr_q;
	assign inj_err_o      = inj_q;
	assign reseed_o       = reseed_q;

	ap_penable_in_sel: assert property (@(posedge clk) disable iff (rst_i)
		penable_i |-> psel_i);

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
dbg_pkg.sv
jtag_pkg.sv
jtag_tap.sv
dbg_reg_bank.sv
prbs_engine.sv
jtag_dbg_top.sv
tb_jtag_dbg.sv

// ==== jtag_dbg_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defs.svh"

module jtag_dbg_top (
	input wire logic clk,
	input wire logic rst_i,

	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,

	output logic [3:0] ibuf_disable_o
);
	// APB between TAP and bank
	logic psel;
	logic penable;
	logic pwrite;
	dbg_pkg::dbg_addr_t paddr;
	logic [`DBG_DATA_W-1:0] pwdata;
	logic [`DBG_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;

	// PRBS control and monitors
	logic chk_en;
	logic gen_en;
	dbg_pkg::prbs_poly_t poly;
	logic invert;
	logic clr_cnt;
	logic inj_err;
	logic reseed;
	logic [`DBG_DATA_W-1:0] err_cnt;
	logic [`PRBS_TOT_W-1:0] tot_cnt;
	logic locked;

	jtag_tap jtag_tap_i (
		.clk(clk),
		.rst_i(rst_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tdo_o(tdo_o),
		.psel_o(psel),
		.penable_o(penable),
		.pwrite_o(pwrite),
		.paddr_o(paddr),
		.pwdata_o(pwdata),
		.prdata_i(prdata),
		.pready_i(pready),
		.pslverr_i(pslverr)
	);

	dbg_reg_bank dbg_reg_bank_i (
		.clk(clk),
		.rst_i(rst_i),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr),
		.ibuf_disable_o(ibuf_disable_o),
		.chk_en_o(chk_en),
		.gen_en_o(gen_en),
		.poly_o(poly),
		.invert_o(invert),
		.clr_cnt_o(clr_cnt),
		.inj_err_o(inj_err),
		.reseed_o(reseed),
		.err_cnt_i(err_cnt),
		.tot_cnt_i(tot_cnt),
		.locked_i(locked)
	);

	prbs_engine prbs_engine_i (
		.clk(clk),
		.rst_i(rst_i),
		.chk_en_i(chk_en),
		.gen_en_i(gen_en),
		.poly_i(poly),
		.invert_i(invert),
		.clr_cnt_i(clr_cnt),
		.inj_err_i(inj_err),
		.reseed_i(reseed),
		.err_cnt_o(err_cnt),
		.tot_cnt_o(tot_cnt),
		.locked_o(locked)
	);

endmodule

`default_nettype wire

// ==== jtag_pkg.sv ====
`default_nettype none

`include "dbg_defs.svh"

package jtag_pkg;

	// IEEE 1149.1 TAP states, standard encoding
	typedef enum logic [3:0] {
		TAP_RESET  = 4'hF,
		TAP_IDLE   = 4'hC,
		SELECT_DR  = 4'h7,
		CAPTURE_DR = 4'h6,
		SHIFT_DR   = 4'h2,
		EXIT1_DR   = 4'h1,
		PAUSE_DR   = 4'h3,
		EXIT2_DR   = 4'h0,
		UPDATE_DR  = 4'h5,
		SELECT_IR  = 4'h4,
		CAPTURE_IR = 4'hE,
		SHIFT_IR   = 4'hA,
		EXIT1_IR   = 4'h9,
		PAUSE_IR   = 4'hB,
		EXIT2_IR   = 4'h8,
		UPDATE_IR  = 4'hD
	} tap_state_t;

	// Unlisted codes behave as BYPASS
	typedef enum logic [`JTAG_IR_W-1:0] {
		IDCODE     = `JTAG_IR_W'(4'h1),
		REG_ACCESS = `JTAG_IR_W'(4'h8),
		BYPASS     = '1
	} jtag_instr_t;

	// Shifted in, decoded at Update-DR
	typedef struct packed {
		logic                   wr;
		logic [`DBG_ADDR_W-1:0] addr;
		logic [`DBG_DATA_W-1:0] wdata;
	} dr_cmd_t;

	// Loaded at Capture-DR from the last APB result
	typedef struct packed {
		logic                   err;
		logic [`DBG_ADDR_W-1:0] addr;
		logic [`DBG_DATA_W-1:0] rdata;
	} dr_resp_t;

	typedef union packed {
		dr_cmd_t  cmd;
		dr_resp_t resp;
	} dr_word_t;

endpackage

`default_nettype wire

// ==== jtag_tap.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defs.svh"

module jtag_tap (
	input wire logic clk,
	input wire logic rst_i,

	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,

	output logic psel_o,
	output logic penable_o,
	output logic pwrite_o,
	output dbg_pkg::dbg_addr_t paddr_o,
	output logic [`DBG_DATA_W-1:0] pwdata_o,
	input wire logic [`DBG_DATA_W-1:0] prdata_i,
	input wire logic pready_i,
	input wire logic pslverr_i
);
	logic [1:0] tck_sync_q;
	logic [1:0] tms_sync_q;
	logic [1:0] tdi_sync_q;
	logic [1:0] trst_sync_q;
	logic tck_prev_q;
	logic tck_rise;
	logic tck_fall;
	logic tap_rst;
	logic tms;
	logic tdi;

	jtag_pkg::tap_state_t state_q;
	jtag_pkg::tap_state_t state_d;
	jtag_pkg::jtag_instr_t ir_q;
	logic [`JTAG_IR_W-1:0] ir_sr_q;
	logic [31:0] idc_sr_q;
	logic byp_q;
	jtag_pkg::dr_word_t dr_q;
	jtag_pkg::dr_word_t resp_q;
	logic dr_tdo;
	logic tdo_q;

	logic upd_req;
	logic psel_q;
	logic penable_q;
	logic pwrite_q;
	dbg_pkg::dbg_addr_t paddr_q;
	logic [`DBG_DATA_W-1:0] pwdata_q;

	// Pins oversampled in clk
	always_ff @(posedge clk) begin
		if (rst_i) begin
			tck_sync_q  <= '0;
			tms_sync_q  <= '0;
			tdi_sync_q  <= '0;
			trst_sync_q <= '0;
			tck_prev_q  <= 1'b0;
		end else begin
			tck_sync_q  <= {tck_sync_q[0], tck_i};
			tms_sync_q  <= {tms_sync_q[0], tms_i};
			tdi_sync_q  <= {tdi_sync_q[0], tdi_i};
			trst_sync_q <= {trst_sync_q[0], trst_n_i};
			tck_prev_q  <= tck_sync_q[1];
		end
	end

	assign tck_rise = tck_sync_q[1] & ~tck_prev_q;
	assign tck_fall = ~tck_sync_q[1] & tck_prev_q;
	assign tap_rst  = rst_i | ~trst_sync_q[1];
	assign tms      = tms_sync_q[1];
	assign tdi      = tdi_sync_q[1];

	always_comb begin
		case (state_q)
			jtag_pkg::TAP_RESET:  state_d = tms ? jtag_pkg::TAP_RESET : jtag_pkg::TAP_IDLE;
			jtag_pkg::TAP_IDLE:   state_d = tms ? jtag_pkg::SELECT_DR : jtag_pkg::TAP_IDLE;
			jtag_pkg::SELECT_DR:  state_d = tms ? jtag_pkg::SELECT_IR : jtag_pkg::CAPTURE_DR;
			jtag_pkg::CAPTURE_DR: state_d = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::SHIFT_DR:   state_d = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::EXIT1_DR:   state_d = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::PAUSE_DR:   state_d = tms ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::EXIT2_DR:   state_d = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::UPDATE_DR:  state_d = tms ? jtag_pkg::SELECT_DR : jtag_pkg::TAP_IDLE;
			jtag_pkg::SELECT_IR:  state_d = tms ? jtag_pkg::TAP_RESET : jtag_pkg::CAPTURE_IR;
			jtag_pkg::CAPTURE_IR: state_d = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::SHIFT_IR:   state_d = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::EXIT1_IR:   state_d = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::PAUSE_IR:   state_d = tms ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::EXIT2_IR:   state_d = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::UPDATE_IR:  state_d = tms ? jtag_pkg::SELECT_DR : jtag_pkg::TAP_IDLE;
			default:              state_d = jtag_pkg::TAP_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (tap_rst) begin
			state_q <= jtag_pkg::TAP_RESET;
			ir_q    <= jtag_pkg::IDCODE;
		end else if (tck_rise) begin
			state_q <= state_d;
			if (state_q == jtag_pkg::TAP_RESET) begin
				ir_q <= jtag_pkg::IDCODE;
			end else if (state_q == jtag_pkg::UPDATE_IR) begin
				ir_q <= jtag_pkg::jtag_instr_t'(ir_sr_q);
			end
		end
	end

	// Capture and shift paths, LSB first out
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			case (state_q)
				jtag_pkg::CAPTURE_IR: ir_sr_q <= {{(`JTAG_IR_W-2){1'b0}}, 2'b01};
				jtag_pkg::SHIFT_IR:   ir_sr_q <= {tdi, ir_sr_q[`JTAG_IR_W-1:1]};
				jtag_pkg::CAPTURE_DR: begin
					case (ir_q)
						jtag_pkg::IDCODE:     idc_sr_q <= `DBG_IDCODE;
						jtag_pkg::REG_ACCESS: dr_q <= resp_q;
						default:              byp_q <= 1'b0;
					endcase
				end
				jtag_pkg::SHIFT_DR: begin
					case (ir_q)
						jtag_pkg::IDCODE:     idc_sr_q <= {tdi, idc_sr_q[31:1]};
						jtag_pkg::REG_ACCESS: dr_q <= jtag_pkg::dr_word_t'({tdi, dr_q[20:1]});
						default:              byp_q <= tdi;
					endcase
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		case (ir_q)
			jtag_pkg::IDCODE:     dr_tdo = idc_sr_q[0];
			jtag_pkg::REG_ACCESS: dr_tdo = dr_q[0];
			default:              dr_tdo = byp_q;
		endcase
	end

	// tdo moves on the falling tck edge
	always_ff @(posedge clk) begin
		if (tap_rst) begin
			tdo_q <= 1'b0;
		end else if (tck_fall) begin
			case (state_q)
				jtag_pkg::SHIFT_DR: tdo_q <= dr_tdo;
				jtag_pkg::SHIFT_IR: tdo_q <= ir_sr_q[0];
				default:            tdo_q <= 1'b0;
			endcase
		end
	end

	assign tdo_o = tdo_q;

	assign upd_req = tck_rise & (state_q == jtag_pkg::UPDATE_DR) &
		(ir_q == jtag_pkg::REG_ACCESS) & ~psel_q;

	// One APB transfer per Update-DR
	always_ff @(posedge clk) begin
		if (tap_rst) begin
			psel_q    <= 1'b0;
			penable_q <= 1'b0;
			resp_q    <= '0;
		end else if (upd_req) begin
			psel_q <= 1'b1;
		end else if (psel_q && !penable_q) begin
			penable_q <= 1'b1;
		end else if (penable_q && pready_i) begin
			psel_q           <= 1'b0;
			penable_q        <= 1'b0;
			resp_q.resp.err  <= pslverr_i;
			resp_q.resp.addr <= paddr_q;
			resp_q.resp.rdata <= prdata_i;
		end
	end

	always_ff @(posedge clk) begin
		if (upd_req) begin
			pwrite_q <= dr_q.cmd.wr;
			paddr_q  <= dbg_pkg::dbg_addr_t'(dr_q.cmd.addr);
			pwdata_q <= dr_q.cmd.wdata;
		end
	end

	assign psel_o    = psel_q;
	assign penable_o = penable_q;
	assign pwrite_o  = pwrite_q;
	assign paddr_o   = paddr_q;
	assign pwdata_o  = pwdata_q;

	ap_psel_hold: assert property (@(posedge clk) disable iff (tap_rst)
		psel_q && !(penable_q && pready_i) |=> psel_q);

	ap_req_stable: assert property (@(posedge clk) disable iff (tap_rst)
		psel_q && !(penable_q && pready_i) |=>
		$stable(paddr_q) && $stable(pwrite_q) && $stable(pwdata_q));

endmodule

`default_nettype wire

// ==== prbs_engine.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defs.svh"

module prbs_engine (
	input wire logic clk,
	input wire logic rst_i,

	input wire logic chk_en_i,
	input wire logic gen_en_i,
	input wire dbg_pkg::prbs_poly_t poly_i,
	input wire logic invert_i,
	input wire logic clr_cnt_i,
	input wire logic inj_err_i,
	input wire logic reseed_i,

	output logic [`DBG_DATA_W-1:0] err_cnt_o,
	output logic [`PRBS_TOT_W-1:0] tot_cnt_o,
	output logic locked_o
);
	localparam int LFSR_W = 23;

	logic [LFSR_W-1:0] gen_q;
	logic gen_fb;
	logic tx_q;
	logic tx_vld_q;

	logic [LFSR_W-1:0] chk_q;
	logic rx_bit;
	logic rx_take;
	logic chk_pred;
	logic [4:0] fill_q;
	logic fill_done;
	logic checking;
	logic bit_err;

	logic [`DBG_DATA_W-1:0] err_cnt_q;
	logic [`PRBS_TOT_W-1:0] tot_cnt_q;
	logic [5:0] run_q;

	// Newest bit sits in bit 0
	function automatic logic lfsr_fb(input logic [LFSR_W-1:0] s, input dbg_pkg::prbs_poly_t p);
		case (p)
			dbg_pkg::PRBS7:  return s[6] ^ s[5];
			dbg_pkg::PRBS9:  return s[8] ^ s[4];
			dbg_pkg::PRBS15: return s[14] ^ s[13];
			default:         return s[22] ^ s[17];
		endcase
	endfunction

	assign gen_fb = lfsr_fb(gen_q, poly_i);

	// Inject corrupts the line bit only, the LFSR keeps the true one
	always_ff @(posedge clk) begin
		if (rst_i || reseed_i) begin
			gen_q    <= '1;
			tx_q     <= 1'b0;
			tx_vld_q <= 1'b0;
		end else begin
			tx_vld_q <= gen_en_i;
			if (gen_en_i) begin
				gen_q <= {gen_q[LFSR_W-2:0], gen_fb};
				tx_q  <= gen_fb ^ inj_err_i;
			end
		end
	end

	assign rx_bit    = tx_q ^ invert_i;
	assign rx_take   = chk_en_i & tx_vld_q;
	assign chk_pred  = lfsr_fb(chk_q, poly_i);
	assign fill_done = (fill_q == 5'(LFSR_W));
	assign checking  = rx_take & fill_done;
	assign bit_err   = checking & (rx_bit ^ chk_pred);

	always_ff @(posedge clk) begin
		if (rx_take) begin
			chk_q <= {chk_q[LFSR_W-2:0], rx_bit};
		end
	end

	// History must refill before bits are judged
	always_ff @(posedge clk) begin
		if (rst_i || !chk_en_i || reseed_i) begin
			fill_q <= '0;
		end else if (rx_take && !fill_done) begin
			fill_q <= fill_q + 5'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i || clr_cnt_i) begin
			err_cnt_q <= '0;
			tot_cnt_q <= '0;
			run_q     <= '0;
		end else if (checking) begin
			tot_cnt_q <= tot_cnt_q + 1'b1;
			if (bit_err) begin
				run_q <= '0;
				if (!(&err_cnt_q)) begin
					err_cnt_q <= err_cnt_q + 1'b1;
				end
			end else if (!run_q[5]) begin
				run_q <= run_q + 6'd1;
			end
		end
	end

	assign err_cnt_o = err_cnt_q;
	assign tot_cnt_o = tot_cnt_q;
	// 32 clean bits in a row
	assign locked_o  = run_q[5];

	ap_cnt_monotonic: assert property (@(posedge clk) disable iff (rst_i)
		!clr_cnt_i |=> (err_cnt_q >= $past(err_cnt_q)) && (tot_cnt_q >= $past(tot_cnt_q)));

endmodule

`default_nettype wire

// ==== tb_jtag_dbg.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "dbg_defs.svh"

module tb_jtag_dbg;

	// Rough budget of 130 scans at about 230 clk each, run windows and margin
	localparam int TIMEOUT_CYCLES = 60000;
	localparam int RUN_CLKS = 400;
	localparam int DR_W = $bits(jtag_pkg::dr_word_t);

	logic clk;
	logic rst;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	wire logic tdo;
	wire logic [3:0] ibuf_disable;

	integer seed;
	int cycle_cnt = 0;
	int fail_cnt = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	jtag_dbg_top jtag_dbg_top_i (
		.clk(clk),
		.rst_i(rst),
		.tck_i(tck),
		.tms_i(tms),
		.tdi_i(tdi),
		.trst_n_i(trst_n),
		.tdo_o(tdo),
		.ibuf_disable_o(ibuf_disable)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic report_fail(input string msg);
		fail_cnt++;
		$display("[FAIL] t=%0t %s", $time, msg);
	endtask

	task automatic check_resp(input jtag_pkg::dr_word_t got, input jtag_pkg::dr_word_t exp,
		input string what);
		if (got.resp.err !== exp.resp.err || got.resp.addr !== exp.resp.addr ||
			got.resp.rdata !== exp.resp.rdata) begin
			report_fail($sformatf("%s: got err=%0b addr=%0d data=%h, expected err=%0b addr=%0d data=%h",
				what, got.resp.err, got.resp.addr, got.resp.rdata,
				exp.resp.err, exp.resp.addr, exp.resp.rdata));
		end
	endtask

	task automatic check_idcode(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_pad(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp) begin
			report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_bypass(input logic [`DBG_DATA_W-1:0] got,
		input logic [`DBG_DATA_W-1:0] exp, input string what);
		if (got !== exp) begin
			report_fail($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (fail_cnt == errs_before) begin
			tests_passed++;
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d check(s) wrong", name, fail_cnt - errs_before);
		end
	endtask

	function automatic jtag_pkg::dr_word_t make_resp(input logic err,
		input dbg_pkg::dbg_addr_t addr, input logic [`DBG_DATA_W-1:0] rdata);
		jtag_pkg::dr_word_t w;
		w = '0;
		w.resp.err = err;
		w.resp.addr = addr;
		w.resp.rdata = rdata;
		return w;
	endfunction

	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk);
	endtask

	// 8 clk per tck period, tdo read just before the rising edge
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(posedge clk);
		#1;
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		repeat (4) @(posedge clk);
		#1;
		tdo_v = tdo;
		tck = 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic tap_reset();
		logic unused;
		repeat (5) tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic scan_ir(input logic [`JTAG_IR_W-1:0] instr);
		logic unused;
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (int i = 0; i < `JTAG_IR_W; i++) begin
			tck_cycle(i == `JTAG_IR_W - 1, instr[i], unused);
		end
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	// Idle to Idle, one extra idle tck lets the APB transfer finish
	task automatic scan_dr(input int n, input logic [31:0] din, output logic [31:0] dout);
		logic bit_out;
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (int i = 0; i < n; i++) begin
			tck_cycle(i == n - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	// Shifts one command in, returns the response of the previous transfer
	task automatic reg_cmd(input logic wr, input dbg_pkg::dbg_addr_t addr,
		input logic [`DBG_DATA_W-1:0] wdata, output jtag_pkg::dr_word_t prev);
		jtag_pkg::dr_word_t word;
		logic [31:0] dout;
		word = '0;
		word.cmd.wr = wr;
		word.cmd.addr = addr;
		word.cmd.wdata = wdata;
		scan_dr(DR_W, 32'(word), dout);
		prev = jtag_pkg::dr_word_t'(dout[DR_W-1:0]);
	endtask

	task automatic reg_write(input dbg_pkg::dbg_addr_t addr, input logic [`DBG_DATA_W-1:0] wdata,
		output jtag_pkg::dr_word_t resp);
		jtag_pkg::dr_word_t unused;
		reg_cmd(1'b1, addr, wdata, unused);
		reg_cmd(1'b0, addr, '0, resp);
	endtask

	task automatic reg_read(input dbg_pkg::dbg_addr_t addr, output jtag_pkg::dr_word_t resp);
		jtag_pkg::dr_word_t unused;
		reg_cmd(1'b0, addr, '0, unused);
		reg_cmd(1'b0, addr, '0, resp);
	endtask

	task automatic test_idcode();
		int errs0;
		logic [31:0] dout;
		errs0 = fail_cnt;
		check_pad(ibuf_disable, 4'h0, "pads after reset");
		tap_reset();
		scan_dr(32, 32'h0, dout);
		check_idcode(dout, `DBG_IDCODE, "IDCODE after TAP reset");
		finish_test("idcode", errs0);
	endtask

	task automatic bypass_once(input logic [`JTAG_IR_W-1:0] instr, input string what);
		logic [`DBG_DATA_W-1:0] pat;
		logic [31:0] dout;
		pat = 16'($random(seed));
		scan_ir(instr);
		scan_dr(`DBG_DATA_W + 1, {15'h0, 1'b0, pat}, dout);
		check_bypass(dout[`DBG_DATA_W:1], pat, what);
	endtask

	task automatic test_bypass();
		int errs0;
		errs0 = fail_cnt;
		bypass_once(`JTAG_IR_W'(jtag_pkg::BYPASS), "BYPASS shift");
		bypass_once(`JTAG_IR_W'(4'h5), "unused code shift");
		finish_test("bypass", errs0);
	endtask

	task automatic test_reg_rw();
		int errs0;
		jtag_pkg::dr_word_t resp;
		logic [`DBG_DATA_W-1:0] d;
		logic [`DBG_DATA_W-1:0] ctrl_m;
		logic [`DBG_DATA_W-1:0] pad_m;
		errs0 = fail_cnt;
		ctrl_m = '0;
		pad_m = '0;
		scan_ir(`JTAG_IR_W'(jtag_pkg::REG_ACCESS));
		repeat (3) begin
			d = 16'($random(seed));
			// A write returns the register as it was before the write
			reg_write(dbg_pkg::CTRL, d, resp);
			check_resp(resp, make_resp(1'b0, dbg_pkg::CTRL, ctrl_m), "CTRL write");
			ctrl_m = d & 16'h001F;
			reg_read(dbg_pkg::CTRL, resp);
			check_resp(resp, make_resp(1'b0, dbg_pkg::CTRL, ctrl_m), "CTRL read back");
			d = 16'($random(seed));
			reg_write(dbg_pkg::PAD, d, resp);
			check_resp(resp, make_resp(1'b0, dbg_pkg::PAD, pad_m), "PAD write");
			pad_m = d & 16'h000F;
			reg_read(dbg_pkg::PAD, resp);
			check_resp(resp, make_resp(1'b0, dbg_pkg::PAD, pad_m), "PAD read back");
			check_pad(ibuf_disable, pad_m[3:0], "ibuf_disable pins");
		end
		// Random CTRL values may have started the PRBS engine
		reg_write(dbg_pkg::CTRL, '0, resp);
		reg_write(dbg_pkg::CMD, 16'h0001, resp);
		finish_test("register read/write", errs0);
	endtask

	task automatic test_reg_errors();
		int errs0;
		jtag_pkg::dr_word_t resp;
		dbg_pkg::dbg_addr_t bad;
		errs0 = fail_cnt;
		reg_write(dbg_pkg::ERR_CNT, 16'($random(seed)), resp);
		check_resp(resp, make_resp(1'b1, dbg_pkg::ERR_CNT, '0), "write to ERR_CNT");
		bad = dbg_pkg::dbg_addr_t'(4'd7 + 4'($unsigned($random(seed)) % 9));
		reg_read(bad, resp);
		check_resp(resp, make_resp(1'b1, bad, '0), "read of unmapped address");
		reg_read(dbg_pkg::ERR_CNT, resp);
		check_resp(resp, make_resp(1'b0, dbg_pkg::ERR_CNT, '0), "ERR_CNT after bad write");
		finish_test("register errors", errs0);
	endtask

	task automatic test_prbs(input dbg_pkg::prbs_poly_t poly);
		int errs0;
		jtag_pkg::dr_word_t resp;
		logic [`DBG_DATA_W-1:0] ctrl_run;
		logic [`DBG_DATA_W-1:0] tot_lo;
		logic [`DBG_DATA_W-1:0] tot_hi;
		errs0 = fail_cnt;
		// chk_en bit 0, gen_en bit 1, poly bits 3:2
		ctrl_run = 16'h0003 | {12'h0, poly, 2'b00};
		reg_write(dbg_pkg::CTRL, '0, resp);
		reg_write(dbg_pkg::CMD, 16'h0005, resp);
		reg_write(dbg_pkg::CTRL, ctrl_run, resp);
		wait_clks(RUN_CLKS);
		reg_write(dbg_pkg::CTRL, ctrl_run & 16'hFFFE, resp);
		reg_read(dbg_pkg::STATUS, resp);
		check_resp(resp, make_resp(1'b0, dbg_pkg::STATUS, 16'h0001), "STATUS after clean run");
		reg_read(dbg_pkg::ERR_CNT, resp);
		check_resp(resp, make_resp(1'b0, dbg_pkg::ERR_CNT, '0), "ERR_CNT after clean run");
		reg_read(dbg_pkg::TOT_LO, resp);
		tot_lo = resp.resp.rdata;
		reg_read(dbg_pkg::TOT_HI, resp);
		tot_hi = resp.resp.rdata;
		if ({tot_hi, tot_lo} == 32'h0) begin
			report_fail($sformatf("total bit count is zero for %s", poly.name()));
		end
		// One injected bit is seen once directly and once per tap
		reg_write(dbg_pkg::CMD, 16'h0001, resp);
		reg_write(dbg_pkg::CTRL, ctrl_run, resp);
		reg_write(dbg_pkg::CMD, 16'h0002, resp);
		reg_read(dbg_pkg::ERR_CNT, resp);
		check_resp(resp, make_resp(1'b0, dbg_pkg::ERR_CNT, 16'd3), "ERR_CNT after inject");
		finish_test($sformatf("prbs %s", poly.name()), errs0);
	endtask

	task automatic test_invert();
		int errs0;
		jtag_pkg::dr_word_t resp;
		logic [`DBG_DATA_W-1:0] tot_lo;
		errs0 = fail_cnt;
		reg_write(dbg_pkg::CTRL, '0, resp);
		reg_write(dbg_pkg::CMD, 16'h0005, resp);
		reg_write(dbg_pkg::CTRL, 16'h0013, resp);
		wait_clks(RUN_CLKS);
		reg_write(dbg_pkg::CTRL, 16'h0012, resp);
		reg_read(dbg_pkg::TOT_LO, resp);
		tot_lo = resp.resp.rdata;
		if (tot_lo == '0) begin
			report_fail("total bit count is zero with invert set");
		end
		reg_read(dbg_pkg::ERR_CNT, resp);
		check_resp(resp, make_resp(1'b0, dbg_pkg::ERR_CNT, tot_lo), "ERR_CNT with invert");
		finish_test("prbs invert", errs0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		seed = 32'h21eeb847;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		test_idcode();
		test_bypass();
		test_reg_rw();
		test_reg_errors();
		test_prbs(dbg_pkg::PRBS7);
		test_prbs(dbg_pkg::PRBS9);
		test_prbs(dbg_pkg::PRBS15);
		test_prbs(dbg_pkg::PRBS23);
		test_invert();

		$display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
		if (fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
